// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = armCoreTb
FILELIST  = sources.f
BUILD_DIR = obj_dir

.PHONY: sim clean

# Simulation output goes to stderr, grep decides the exit status
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep "^TESTBENCH PASSED$$" > /dev/null

clean:
	rm -rf $(BUILD_DIR)

// File: source/alu.sv
// Add, subtract, and, or ALU
`timescale 1ns/1ps
`default_nettype none

module alu
   import armCtrlPkg::*;
(
   input  logic [31:0] a,
   input  logic [31:0] b,
   input  aluOpT       aluOp,
   output logic [31:0] result,
   output logic [3:0]  flags    // NZCV
);

   logic        isSub;
   logic        isArith;  // C and V meaningful
   logic [31:0] bMux;     // b, inverted for subtract
   logic [32:0] sum;      // Bit 32 is carry out

   assign isSub   = (aluOp == aluSub);
   assign isArith = (aluOp == aluAdd) | isSub;

   // a - b as a + ~b + 1
   assign bMux = isSub ? ~b : b;
   assign sum  = {1'b0, a} + {1'b0, bMux} + {32'b0, isSub};

   always_comb
   begin
      case (aluOp)
         aluAnd:  result = a & b;
         aluOrr:  result = a | b;
         default: result = sum[31:0];  // Add and subtract
      endcase
   end

   always_comb
   begin
      flags        = 4'b0000;
      flags[flagN] = result[31];
      flags[flagZ] = (result == 32'b0);
      flags[flagC] = isArith & sum[32];
      // Adder operands of one sign giving a result of the other
      flags[flagV] = isArith & ~(a[31] ^ b[31] ^ isSub) & (a[31] ^ sum[31]);
   end

endmodule

`default_nettype wire

// File: source/armCore.sv
// Single-cycle ARM core top
`timescale 1ns/1ps
`default_nettype none

module armCore
   import armIsaPkg::*, armCtrlPkg::*;
#(
   parameter logic [31:0] resetPc = 32'h0000_0000  // First fetch address
)
(
   input  logic        clk,
   input  logic        reset,
   input  instrWord    instr,      // Fetched word for the current pc
   input  logic        pcReady,    // Low holds the PC
   input  logic [31:0] readData,   // Load data, same cycle
   output logic [31:0] pc,
   output logic        memWrite,   // Store that passed its condition
   output logic        memStrobe,  // Any LDR or STR
   output logic [31:0] aluResult,  // Also the data address
   output logic [31:0] writeData   // Store data
);

   // Raw decode before condition check
   logic       regWriteRaw;
   logic       memWriteRaw;
   logic       pcWriteRaw;
   logic [1:0] flagWrite;   // [1] NZ, [0] CV

   // Datapath steering
   logic       aluSrc;
   logic       memToReg;
   immSrcT     immSrc;
   aluOpT      aluOp;
   logic [1:0] regSrc;

   // Condition-gated writes
   logic       regWrite;
   logic       pcSrc;
   logic [3:0] aluFlags;

   instrDecoder instrDecoder_inst
   (
      .instr       (instr),
      .regWriteRaw (regWriteRaw),
      .memWriteRaw (memWriteRaw),
      .pcWriteRaw  (pcWriteRaw),
      .flagWrite   (flagWrite),
      .aluSrc      (aluSrc),
      .memToReg    (memToReg),
      .immSrc      (immSrc),
      .aluOp       (aluOp),
      .regSrc      (regSrc),
      .memStrobe   (memStrobe)
   );

   condUnit condUnit_inst
   (
      .clk         (clk),
      .reset       (reset),
      .cond        (instr.dp.cond),  // Same position in all layouts
      .aluFlags    (aluFlags),
      .flagWrite   (flagWrite),
      .regWriteRaw (regWriteRaw),
      .memWriteRaw (memWriteRaw),
      .pcWriteRaw  (pcWriteRaw),
      .regWrite    (regWrite),
      .memWrite    (memWrite),
      .pcSrc       (pcSrc)
   );

   dataPath #(.resetPc(resetPc)) dataPath_inst
   (
      .clk       (clk),
      .reset     (reset),
      .instr     (instr),
      .pcReady   (pcReady),
      .regSrc    (regSrc),
      .regWrite  (regWrite),
      .immSrc    (immSrc),
      .aluSrc    (aluSrc),
      .aluOp     (aluOp),
      .memToReg  (memToReg),
      .pcSrc     (pcSrc),
      .readData  (readData),
      .aluFlags  (aluFlags),
      .pc        (pc),
      .aluResult (aluResult),
      .writeData (writeData)
   );

endmodule

`default_nettype wire

// File: source/armCtrlPkg.sv
// Core control encodings
`default_nettype none

package armCtrlPkg;

   // Immediate extension select
   typedef enum logic [1:0]
   {
      imm8     = 2'b00,  // DP immediate, zero extended
      imm12    = 2'b01,  // LDR/STR offset, zero extended
      branch24 = 2'b10   // Branch offset, signed and word scaled
   } immSrcT;

   // ALU operation where bit 0 marks subtract and bit 1 a logic op
   typedef enum logic [1:0]
   {
      aluAdd = 2'b00,
      aluSub = 2'b01,
      aluAnd = 2'b10,
      aluOrr = 2'b11
   } aluOpT;

   // Bit positions inside the 4-bit NZCV vector
   typedef enum logic [1:0]
   {
      flagV = 2'd0,  // Signed overflow
      flagC = 2'd1,  // Carry out
      flagZ = 2'd2,  // Zero result
      flagN = 2'd3   // Negative result
   } flagBits;

endpackage

`default_nettype wire

// File: source/armIsaPkg.sv
// ARMv4 subset instruction encodings
`default_nettype none

package armIsaPkg;

   // Data-processing layout for ADD/SUB/AND/ORR
   typedef struct packed
   {
      logic [3:0]  cond;      // Condition field
      logic [1:0]  op;        // 00 for data processing
      logic        immFlag;   // 1 = immediate operand2
      logic [3:0]  cmd;       // Operation select
      logic        s;         // Update NZCV
      logic [3:0]  rn;        // First source
      logic [3:0]  rd;        // Destination
      logic [11:0] operand2;  // imm8 in [7:0] or rm in [3:0]
   } instrDp;

   // Load/store layout for LDR/STR with immediate offset
   typedef struct packed
   {
      logic [3:0]  cond;
      logic [1:0]  op;        // 01 for memory
      logic        regOffset; // Register offset form not supported
      logic        p;         // Pre-index
      logic        u;         // Up, offset added
      logic        b;         // Byte access
      logic        w;         // Writeback
      logic        l;         // 1 = LDR, 0 = STR
      logic [3:0]  rn;        // Base register
      logic [3:0]  rd;        // Load target or store source
      logic [11:0] imm12;     // Zero-extended offset
   } instrMem;

   // Branch layout
   typedef struct packed
   {
      logic [3:0]  cond;
      logic [1:0]  op;        // 10 for branch
      logic [1:0]  funct;     // [0] is link and BL not supported
      logic [23:0] imm24;     // Word offset, signed
   } instrBr;

   // One fetched word, read through whichever layout op selects
   typedef union packed
   {
      instrDp  dp;
      instrMem mem;
      instrBr  br;
   } instrWord;

   // Major opcode values in bits 27:26
   localparam logic [1:0] opDp  = 2'b00;
   localparam logic [1:0] opMem = 2'b01;
   localparam logic [1:0] opBr  = 2'b10;

   // Data-processing cmd codes in bits 24:21
   localparam logic [3:0] cmdAnd = 4'b0000;
   localparam logic [3:0] cmdSub = 4'b0010;
   localparam logic [3:0] cmdAdd = 4'b0100;
   localparam logic [3:0] cmdOrr = 4'b1100;

   localparam logic [3:0] condAl = 4'b1110;  // Always execute

   localparam logic [3:0] regPc = 4'd15;     // R15 is the PC

endpackage

`default_nettype wire

// File: source/condUnit.sv
// Flags and condition check
`timescale 1ns/1ps
`default_nettype none

module condUnit
   import armIsaPkg::*, armCtrlPkg::*;
(
   input  logic       clk,
   input  logic       reset,
   input  logic [3:0] cond,
   input  logic [3:0] aluFlags,
   input  logic [1:0] flagWrite,    // [1] NZ, [0] CV
   input  logic       regWriteRaw,
   input  logic       memWriteRaw,
   input  logic       pcWriteRaw,
   output logic       regWrite,
   output logic       memWrite,
   output logic       pcSrc
);

   logic [3:0] flags;        // Stored NZCV
   logic [1:0] flagWriteEn;  // Gated enables
   logic       condEx;       // Condition passed
   logic       ge;           // Signed greater or equal

   // NZ and CV halves load separately
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         flags <= 4'b0000;
      else
      begin
         if (flagWriteEn[1])
            flags[3:2] <= aluFlags[3:2];  // N, Z
         if (flagWriteEn[0])
            flags[1:0] <= aluFlags[1:0];  // C, V
      end
   end

   assign ge = (flags[flagN] == flags[flagV]);

   always_comb
   begin
      case (cond)
         4'b0000: condEx = flags[flagZ];                     // EQ
         4'b0001: condEx = ~flags[flagZ];                    // NE
         4'b0010: condEx = flags[flagC];                     // CS
         4'b0011: condEx = ~flags[flagC];                    // CC
         4'b0100: condEx = flags[flagN];                     // MI
         4'b0101: condEx = ~flags[flagN];                    // PL
         4'b0110: condEx = flags[flagV];                     // VS
         4'b0111: condEx = ~flags[flagV];                    // VC
         4'b1000: condEx = flags[flagC] & ~flags[flagZ];     // HI
         4'b1001: condEx = ~flags[flagC] | flags[flagZ];     // LS
         4'b1010: condEx = ge;                               // GE
         4'b1011: condEx = ~ge;                              // LT
         4'b1100: condEx = ~flags[flagZ] & ge;               // GT
         4'b1101: condEx = flags[flagZ] | ~ge;               // LE
         condAl:  condEx = 1'b1;
         default: condEx = 1'b0;                             // 1111 never executes
      endcase
   end

   // Skipped instruction changes nothing
   assign flagWriteEn = flagWrite & {2{condEx}};
   assign regWrite    = regWriteRaw & condEx;
   assign memWrite    = memWriteRaw & condEx;
   assign pcSrc       = pcWriteRaw & condEx;

endmodule

`default_nettype wire

// File: source/dataPath.sv
// Core datapath
`timescale 1ns/1ps
`default_nettype none

module dataPath
   import armIsaPkg::*, armCtrlPkg::*;
#(
   parameter logic [31:0] resetPc = 32'h0000_0000
)
(
   input  logic        clk,
   input  logic        reset,
   input  instrWord    instr,
   input  logic        pcReady,
   input  logic [1:0]  regSrc,
   input  logic        regWrite,
   input  immSrcT      immSrc,
   input  logic        aluSrc,
   input  aluOpT       aluOp,
   input  logic        memToReg,
   input  logic        pcSrc,
   input  logic [31:0] readData,
   output logic [3:0]  aluFlags,
   output logic [31:0] pc,
   output logic [31:0] aluResult,
   output logic [31:0] writeData
);

   logic [31:0] pcNext;
   logic [31:0] pcPlus4;
   logic [31:0] pcPlus8;    // R15 read value
   logic [3:0]  readAddr1;
   logic [3:0]  readAddr2;
   logic [31:0] srcA;
   logic [31:0] srcB;
   logic [31:0] extImm;
   logic [31:0] result;     // Write-back value, also jump target

   // PC register stalls while pcReady low
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         pc <= resetPc;
      else if (pcReady)
         pc <= pcNext;
   end

   assign pcPlus4 = pc + 32'd4;
   assign pcPlus8 = pc + 32'd8;
   assign pcNext  = pcSrc ? result : pcPlus4;  // Branch or write to R15

   // Register addresses
   assign readAddr1 = regSrc[0] ? regPc : instr.dp.rn;
   assign readAddr2 = regSrc[1] ? instr.dp.rd : instr.dp.operand2[3:0];  // rd for STR

   regFile regFile_inst
   (
      .clk       (clk),
      .writeEn   (regWrite),
      .readAddr1 (readAddr1),
      .readAddr2 (readAddr2),
      .writeAddr (instr.dp.rd),
      .writeData (result),
      .pcPlus8   (pcPlus8),
      .readData1 (srcA),
      .readData2 (writeData)
   );

   // Immediate read through the layout immSrc names
   always_comb
   begin
      case (immSrc)
         imm8:     extImm = {24'b0, instr.dp.operand2[7:0]};
         imm12:    extImm = {20'b0, instr.mem.imm12};
         branch24: extImm = {{6{instr.br.imm24[23]}}, instr.br.imm24, 2'b00};
         default:  extImm = 32'b0;
      endcase
   end

   assign srcB = aluSrc ? extImm : writeData;

   alu alu_inst
   (
      .a      (srcA),
      .b      (srcB),
      .aluOp  (aluOp),
      .result (aluResult),
      .flags  (aluFlags)
   );

   assign result = memToReg ? readData : aluResult;  // LDR loads memory word

endmodule

`default_nettype wire

// File: source/instrDecoder.sv
// Main and ALU instruction decoder
`timescale 1ns/1ps
`default_nettype none

module instrDecoder
   import armIsaPkg::*, armCtrlPkg::*;
(
   input  instrWord    instr,
   output logic        regWriteRaw,
   output logic        memWriteRaw,
   output logic        pcWriteRaw,
   output logic [1:0]  flagWrite,    // [1] NZ, [0] CV
   output logic        aluSrc,       // 1 = immediate operand B
   output logic        memToReg,     // 1 = write back load data
   output immSrcT      immSrc,
   output aluOpT       aluOp,
   output logic [1:0]  regSrc,       // [0] rn -> R15, [1] rm -> rd
   output logic        memStrobe
);

   logic branch;  // B taken if condition passes
   logic isDp;    // ALU op follows cmd field

   // Main decoder on op field
   always_comb
   begin
      regSrc      = 2'b00;
      immSrc      = imm8;
      aluSrc      = 1'b0;
      memToReg    = 1'b0;
      regWriteRaw = 1'b0;
      memWriteRaw = 1'b0;
      memStrobe   = 1'b0;
      branch      = 1'b0;
      isDp        = 1'b0;
      case (instr.dp.op)
         opDp:
         begin
            isDp        = 1'b1;
            regWriteRaw = 1'b1;
            aluSrc      = instr.dp.immFlag;  // imm8 or rm
         end
         opMem:
         begin
            immSrc    = imm12;
            aluSrc    = 1'b1;                // rn + offset
            memStrobe = 1'b1;
            if (instr.mem.l)
            begin
               memToReg    = 1'b1;           // LDR
               regWriteRaw = 1'b1;
            end
            else
            begin
               regSrc[1]   = 1'b1;           // STR reads rd as data
               memWriteRaw = 1'b1;
            end
         end
         opBr:
         begin
            regSrc[0] = 1'b1;                // PC+8 as base
            immSrc    = branch24;
            aluSrc    = 1'b1;
            branch    = 1'b1;
         end
         default: ;                          // Reserved op, no effect
      endcase
   end

   // ALU decoder where non-DP instructions add
   always_comb
   begin
      aluOp     = aluAdd;
      flagWrite = 2'b00;
      if (isDp)
      begin
         case (instr.dp.cmd)
            cmdSub:  aluOp = aluSub;
            cmdAnd:  aluOp = aluAnd;
            cmdOrr:  aluOp = aluOrr;
            default: aluOp = aluAdd;
         endcase
         flagWrite[1] = instr.dp.s;
         // C and V only from arithmetic ops
         flagWrite[0] = instr.dp.s & ((instr.dp.cmd == cmdAdd) | (instr.dp.cmd == cmdSub));
      end
   end

   // Branch or any register write landing in R15
   assign pcWriteRaw = branch | (regWriteRaw & (instr.dp.rd == regPc));

endmodule

`default_nettype wire

// File: source/regFile.sv
// General register file
`timescale 1ns/1ps
`default_nettype none

module regFile
   import armIsaPkg::*;
(
   input  logic        clk,
   input  logic        writeEn,
   input  logic [3:0]  readAddr1,
   input  logic [3:0]  readAddr2,
   input  logic [3:0]  writeAddr,
   input  logic [31:0] writeData,
   input  logic [31:0] pcPlus8,    // Value seen for R15
   output logic [31:0] readData1,
   output logic [31:0] readData2
);

   logic [31:0] regs [14:0];  // R0 to R14

   // R15 writes go to the PC, not here
   always_ff @(posedge clk)
   begin
      if (writeEn && (writeAddr != regPc))
         regs[writeAddr] <= writeData;
   end

   assign readData1 = (readAddr1 == regPc) ? pcPlus8 : regs[readAddr1];
   assign readData2 = (readAddr2 == regPc) ? pcPlus8 : regs[readAddr2];

endmodule

`default_nettype wire

// File: sources.f
+incdir+tb
source/armIsaPkg.sv
source/armCtrlPkg.sv
source/alu.sv
source/regFile.sv
source/condUnit.sv
source/instrDecoder.sv
source/dataPath.sv
source/armCore.sv
tb/armCoreTb.sv

// File: tb/programTable.svh
// Core test program
`ifndef programTableSvh
`define programTableSvh

// execRow columns: instruction, expected pc
// memRow columns: instruction, pcReady, expected pc, memWrite, address, store data
task automatic loadProgram;
   begin
      execRow(dpImm(condAl, cmdAnd, 1'b0, 4'd0, 4'd0, 8'h00), 32'h100);  // r0 = 0
      execRow(dpImm(condAl, cmdAdd, 1'b0, 4'd0, 4'd1, 8'h25), 32'h104);  // r1 = 0x25
      execRow(dpImm(condAl, cmdAdd, 1'b0, 4'd0, 4'd2, 8'hF0), 32'h108);  // r2 = 0xF0
      execRow(dpReg(condAl, cmdAdd, 1'b0, 4'd1, 4'd3, 4'd2), 32'h10C);   // r3 = 0x115
      execRow(dpImm(condAl, cmdSub, 1'b0, 4'd2, 4'd4, 8'h10), 32'h110);  // r4 = 0xE0
      execRow(dpReg(condAl, cmdSub, 1'b0, 4'd1, 4'd5, 4'd2), 32'h114);   // r5 = 0x25 - 0xF0
      execRow(dpImm(condAl, cmdAnd, 1'b0, 4'd2, 4'd6, 8'h3C), 32'h118);  // r6 = 0x30
      execRow(dpReg(condAl, cmdOrr, 1'b0, 4'd1, 4'd7, 4'd2), 32'h11C);   // r7 = 0xF5
      execRow(dpImm(condAl, cmdOrr, 1'b0, 4'd1, 4'd8, 8'h40), 32'h120);  // r8 = 0x65
      execRow(dpReg(condAl, cmdAnd, 1'b0, 4'd3, 4'd9, 4'd7), 32'h124);   // r9 = 0x15
      // Results out through stores
      memRow(memImm(condAl, 1'b0, 4'd0, 4'd3, 12'h010), 1'b1, 32'h128, 1'b1, 32'h10, 32'h115);
      memRow(memImm(condAl, 1'b0, 4'd0, 4'd4, 12'h014), 1'b1, 32'h12C, 1'b1, 32'h14, 32'hE0);
      memRow(memImm(condAl, 1'b0, 4'd0, 4'd5, 12'h018), 1'b1, 32'h130, 1'b1, 32'h18,
             32'hFFFF_FF35);
      memRow(memImm(condAl, 1'b0, 4'd2, 4'd6, 12'h004), 1'b1, 32'h134, 1'b1, 32'hF4, 32'h30);
      memRow(memImm(condAl, 1'b0, 4'd0, 4'd7, 12'h01C), 1'b1, 32'h138, 1'b1, 32'h1C, 32'hF5);
      memRow(memImm(condAl, 1'b0, 4'd0, 4'd8, 12'h020), 1'b1, 32'h13C, 1'b1, 32'h20, 32'h65);
      memRow(memImm(condAl, 1'b0, 4'd0, 4'd9, 12'h024), 1'b1, 32'h140, 1'b1, 32'h24, 32'h15);
      // Load back the r5 word, then store it again
      memRow(memImm(condAl, 1'b1, 4'd0, 4'd10, 12'h018), 1'b1, 32'h144, 1'b0, 32'h18, 32'h0);
      memRow(memImm(condAl, 1'b0, 4'd0, 4'd10, 12'h028), 1'b1, 32'h148, 1'b1, 32'h28,
             32'hFFFF_FF35);
      execRow(dpReg(condAl, cmdSub, 1'b1, 4'd1, 4'd11, 4'd1), 32'h14C);  // Z=1 C=1
      memRow(memImm(condEq, 1'b0, 4'd0, 4'd1, 12'h02C), 1'b1, 32'h150, 1'b1, 32'h2C, 32'h25);
      memRow(memImm(condNe, 1'b0, 4'd0, 4'd2, 12'h030), 1'b1, 32'h154, 1'b0, 32'h30, 32'hF0);
      memRow(memImm(condCs, 1'b0, 4'd0, 4'd3, 12'h034), 1'b1, 32'h158, 1'b1, 32'h34, 32'h115);
      execRow(dpReg(condAl, cmdSub, 1'b1, 4'd1, 4'd11, 4'd2), 32'h15C);  // N=1 Z=0 C=0 V=0
      memRow(memImm(condLt, 1'b0, 4'd0, 4'd4, 12'h038), 1'b1, 32'h160, 1'b1, 32'h38, 32'hE0);
      memRow(memImm(condGt, 1'b0, 4'd0, 4'd6, 12'h03C), 1'b1, 32'h164, 1'b0, 32'h3C, 32'h30);
      execRow(dpImm(condNe, cmdAdd, 1'b0, 4'd0, 4'd12, 8'h77), 32'h168);  // r12 = 0x77
      execRow(branch(condEq, 24'h000004), 32'h16C);  // Not taken
      execRow(branch(condAl, 24'h000002), 32'h170);  // To 0x180
      memRow(memImm(condAl, 1'b0, 4'd0, 4'd12, 12'h040), 1'b1, 32'h180, 1'b1, 32'h40, 32'h77);
      execRow(branch(condAl, 24'hFFFFFC), 32'h184);  // Back to 0x17C
      execRow(dpImm(condAl, cmdAdd, 1'b0, 4'd2, 4'd15, 8'h90), 32'h17C);  // Jump to 0x180
      // Stalled store repeats
      memRow(memImm(condAl, 1'b0, 4'd0, 4'd9, 12'h044), 1'b0, 32'h180, 1'b1, 32'h44, 32'h15);
      memRow(memImm(condAl, 1'b0, 4'd0, 4'd9, 12'h044), 1'b0, 32'h180, 1'b1, 32'h44, 32'h15);
      memRow(memImm(condAl, 1'b0, 4'd0, 4'd9, 12'h044), 1'b1, 32'h180, 1'b1, 32'h44, 32'h15);
      execRow(dpImm(condAl, cmdAnd, 1'b0, 4'd0, 4'd0, 8'h00), 32'h184);
   end
endtask

`endif

// File: tb/armCoreTb.sv
// Single-cycle core testbench
`timescale 1ns/1ps
`default_nettype none

module armCoreTb;

   localparam logic [31:0] resetPc = 32'h0000_0100;  // Off zero to exercise the parameter
   localparam int resetCycles = 16;

   // Condition and cmd encodings from the ARM architecture
   localparam logic [3:0] condEq = 4'h0;
   localparam logic [3:0] condNe = 4'h1;
   localparam logic [3:0] condCs = 4'h2;
   localparam logic [3:0] condLt = 4'hB;
   localparam logic [3:0] condGt = 4'hC;
   localparam logic [3:0] condAl = 4'hE;
   localparam logic [3:0] cmdAnd = 4'h0;
   localparam logic [3:0] cmdSub = 4'h2;
   localparam logic [3:0] cmdAdd = 4'h4;
   localparam logic [3:0] cmdOrr = 4'hC;

   logic        clk = 1'b0;
   logic        reset;
   logic [31:0] instr;
   logic        pcReady;
   logic [31:0] readData;
   logic [31:0] pc;
   logic        memWrite;
   logic        memStrobe;
   logic [31:0] aluResult;
   logic [31:0] writeData;

   logic [31:0] dmem [0:63];  // Word-addressed data memory

   // One entry per table row
   logic [31:0] rowInstr [$];
   logic        rowReady [$];
   logic [31:0] rowPc [$];
   logic        rowMemWrite [$];
   logic        rowStrobe [$];
   logic [31:0] rowAddr [$];
   logic [31:0] rowData [$];

   int checkCount    = 0;
   int errorCount    = 0;
   int otherFailures = 0;
   int cycleCount    = 0;
   int timeoutLimit  = 0;

   always #4 clk = ~clk;  // 8 ns period

   armCore #(.resetPc(resetPc)) armCore_inst
   (
      .clk       (clk),
      .reset     (reset),
      .instr     (instr),
      .pcReady   (pcReady),
      .readData  (readData),
      .pc        (pc),
      .memWrite  (memWrite),
      .memStrobe (memStrobe),
      .aluResult (aluResult),
      .writeData (writeData)
   );

   assign readData = dmem[aluResult[7:2]];  // Combinational load

   always @(posedge clk)
   begin
      if (memWrite)
         dmem[aluResult[7:2]] <= writeData;  // Store at the edge
   end

   // Instruction builders in ARM field order
   function automatic logic [31:0] dpImm(input logic [3:0] cond, input logic [3:0] cmd,
                                         input logic s, input logic [3:0] rn,
                                         input logic [3:0] rd, input logic [7:0] imm8);
      return {cond, 2'b00, 1'b1, cmd, s, rn, rd, 4'h0, imm8};
   endfunction

   function automatic logic [31:0] dpReg(input logic [3:0] cond, input logic [3:0] cmd,
                                         input logic s, input logic [3:0] rn,
                                         input logic [3:0] rd, input logic [3:0] rm);
      return {cond, 2'b00, 1'b0, cmd, s, rn, rd, 8'h00, rm};
   endfunction

   // Pre-indexed, offset added, word, no writeback
   function automatic logic [31:0] memImm(input logic [3:0] cond, input logic l,
                                          input logic [3:0] rn, input logic [3:0] rd,
                                          input logic [11:0] imm12);
      return {cond, 2'b01, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, l, rn, rd, imm12};
   endfunction

   function automatic logic [31:0] branch(input logic [3:0] cond, input logic [23:0] imm24);
      return {cond, 3'b101, 1'b0, imm24};  // Link bit clear
   endfunction

   task automatic addRow(input logic [31:0] ins, input logic ready, input logic [31:0] pcExp,
                         input logic mw, input logic ms, input logic [31:0] addr,
                         input logic [31:0] data);
      rowInstr.push_back(ins);
      rowReady.push_back(ready);
      rowPc.push_back(pcExp);
      rowMemWrite.push_back(mw);
      rowStrobe.push_back(ms);
      rowAddr.push_back(addr);
      rowData.push_back(data);
   endtask

   // No memory access and PC free running
   task automatic execRow(input logic [31:0] ins, input logic [31:0] pcExp);
      addRow(ins, 1'b1, pcExp, 1'b0, 1'b0, 32'h0, 32'h0);
   endtask

   task automatic memRow(input logic [31:0] ins, input logic ready, input logic [31:0] pcExp,
                         input logic mw, input logic [31:0] addr, input logic [31:0] data);
      addRow(ins, ready, pcExp, mw, 1'b1, addr, data);
   endtask

   `include "programTable.svh"

   task automatic checkValue(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
      checkCount++;
      if (actual !== expected)
      begin
         errorCount++;
         $display("ERR %s expected %h actual %h", name, expected, actual);
      end
   endtask

   task automatic checkRow(input int i);
      checkValue($sformatf("row %0d pc", i), rowPc[i], pc);
      checkValue($sformatf("row %0d memWrite", i), {31'b0, rowMemWrite[i]}, {31'b0, memWrite});
      checkValue($sformatf("row %0d memStrobe", i), {31'b0, rowStrobe[i]}, {31'b0, memStrobe});
      if (rowStrobe[i])
      begin
         checkValue($sformatf("row %0d address", i), rowAddr[i], aluResult);
         if (!rowInstr[i][20])  // Loads carry no store data
            checkValue($sformatf("row %0d store data", i), rowData[i], writeData);
      end
   endtask

   task automatic printCounts;
      $display("Checks: %0d, mismatches: %0d, other failures: %0d",
               checkCount, errorCount, otherFailures);
   endtask

   // Watchdog counting cycles after reset
   always @(posedge clk)
   begin
      if (!reset)
      begin
         cycleCount <= cycleCount + 1;
         if (cycleCount > timeoutLimit)
         begin
            otherFailures++;
            $display("Timeout: the program table did not finish within %0d cycles", timeoutLimit);
            printCounts();
            $display("TESTBENCH FAILED");
            $finish;
         end
      end
   end

   initial
   begin
      int i;
      reset   = 1'b1;
      instr   = 32'h0000_0000;  // EQ with flags clear is skipped
      pcReady = 1'b1;
      for (i = 0; i < 64; i++)
         dmem[i] = 32'hd000_0000 + (i * 4);  // Byte address as content
      loadProgram();
      timeoutLimit = 2 * rowInstr.size();
      repeat (resetCycles) @(posedge clk);
      reset <= 1'b0;
      for (i = 0; i < rowInstr.size(); i++)
      begin
         instr   <= rowInstr[i];
         pcReady <= rowReady[i];
         @(negedge clk);  // Outputs settled mid-cycle
         checkRow(i);
         @(posedge clk);
      end
      printCounts();
      if ((errorCount == 0) && (otherFailures == 0))
         $display("TESTBENCH PASSED");
      else
         $display("TESTBENCH FAILED");
      $finish;
   end

endmodule

`default_nettype wire
